//--- hw/mimo_pid_top.sv
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// mimo pid top
// 2x2 MIMO PID, each output is the clamped sum of two PID
// blocks fed from both inputs, set up over wishbone
////////////////////////////////////////////////////////////

module mimo_pid_top (
  input  logic                                        clk,
  input  logic                                        rstn,
  // sample streams
  input  logic signed [pid_pkg::CNI-1:0][pid_pkg::DW-1:0] dat_i,
  output logic signed [pid_pkg::CNO-1:0][pid_pkg::DW-1:0] dat_o,
  // wishbone classic slave
  input  logic                                        wb_cyc_i,
  input  logic                                        wb_stb_i,
  input  logic                                        wb_we_i,
  input  logic [31:0]                                 wb_adr_i,
  input  logic [31:0]                                 wb_dat_i,
  input  logic [3:0]                                  wb_sel_i,
  output logic [31:0]                                 wb_dat_o,
  output logic                                        wb_ack_o
);

  // per block settings and results, index o*2+i
  logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] sp;
  logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] kp;
  logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] ki;
  logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] kd;
  logic        [pid_pkg::NBLK-1:0]                  irst;
  logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] pid_out;

  ////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////

  pid_regs u_regs (
    .clk      (clk),
    .rstn     (rstn),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .sp_o     (sp),
    .kp_o     (kp),
    .ki_o     (ki),
    .kd_o     (kd),
    .irst_o   (irst)
  );

  ////////////////////////////////////////////////////////////
  // pid blocks and output summers
  ////////////////////////////////////////////////////////////

  for (genvar o = 0; o < pid_pkg::CNO; o++) begin : g_out
    for (genvar i = 0; i < pid_pkg::CNI; i++) begin : g_in
      pid_block u_pid (
        .clk    (clk),
        .rstn   (rstn),
        .dat_i  (dat_i[i]),  // block (o,i) watches input i
        .pid_o  (pid_out[o*pid_pkg::CNI+i]),
        .sp_i   (sp[o*pid_pkg::CNI+i]),
        .kp_i   (kp[o*pid_pkg::CNI+i]),
        .ki_i   (ki[o*pid_pkg::CNI+i]),
        .kd_i   (kd[o*pid_pkg::CNI+i]),
        .irst_i (irst[o*pid_pkg::CNI+i])
      );
    end

    // output o mixes both inputs, 3 + 1 cycles total
    mimo_sum_sat u_sum (
      .clk   (clk),
      .rstn  (rstn),
      .a_i   (pid_out[o*pid_pkg::CNI]),
      .b_i   (pid_out[o*pid_pkg::CNI+1]),
      .sum_o (dat_o[o])
    );
  end

endmodule

//--- hw/mimo_sum_sat.sv
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// mimo sum and saturate
// adds two PID results of one output channel and clamps
// the registered sum to the 14 bit signed range
////////////////////////////////////////////////////////////

module mimo_sum_sat (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic signed [pid_pkg::DW-1:0] a_i,   // block (o,0)
  input  logic signed [pid_pkg::DW-1:0] b_i,   // block (o,1)
  output logic signed [pid_pkg::DW-1:0] sum_o  // clamped sum
);

  logic signed [pid_pkg::DW:0] sum;  // 15 bit, cannot wrap

  assign sum = a_i + b_i;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sum_o <= '0;
    end else if (sum > pid_pkg::SAT_MAX) begin
      sum_o <= pid_pkg::SAT_MAX;  // 8191
    end else if (sum < pid_pkg::SAT_MIN) begin
      sum_o <= pid_pkg::SAT_MIN;  // -8192
    end else begin
      sum_o <= sum[pid_pkg::DW-1:0];
    end
  end

  // no wrap, the output keeps the sign shared by both inputs
  a_no_wrap_pos: assert property (
    @(posedge clk) disable iff (!rstn)
    (!a_i[pid_pkg::DW-1] && !b_i[pid_pkg::DW-1]) |=> !sum_o[pid_pkg::DW-1]
  );

  a_no_wrap_neg: assert property (
    @(posedge clk) disable iff (!rstn)
    (a_i[pid_pkg::DW-1] && b_i[pid_pkg::DW-1]) |=> sum_o[pid_pkg::DW-1]
  );

endmodule

//--- hw/pid_block.sv
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// pid block
// one PID core in three pipeline stages with a saturating
// integrator that clears while its reset input is high
////////////////////////////////////////////////////////////

module pid_block (
  input  logic                          clk,
  input  logic                          rstn,
  // data
  input  logic signed [pid_pkg::DW-1:0] dat_i,  // input sample
  output logic signed [pid_pkg::DW-1:0] pid_o,  // controller output
  // settings
  input  logic signed [pid_pkg::DW-1:0] sp_i,   // set point
  input  logic signed [pid_pkg::DW-1:0] kp_i,   // proportional gain
  input  logic signed [pid_pkg::DW-1:0] ki_i,   // integral gain
  input  logic signed [pid_pkg::DW-1:0] kd_i,   // derivative gain
  input  logic                          irst_i  // integrator clear
);

  ////////////////////////////////////////////////////////////
  // stage 1, error
  ////////////////////////////////////////////////////////////

  logic signed [pid_pkg::DW:0] err;       // 15 bit, sp - sample
  logic signed [pid_pkg::DW:0] err_prev;  // error one sample back

  always_ff @(posedge clk) begin
    if (!rstn) begin
      err      <= '0;
      err_prev <= '0;
    end else begin
      err      <= sp_i - dat_i;  // one extra bit, no overflow
      err_prev <= err;
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2, P, I and D terms
  ////////////////////////////////////////////////////////////

  logic signed [2*pid_pkg::DW:0]   kp_mult;  // 14 x 15 -> 29 bit
  logic signed [2*pid_pkg::DW:0]   ki_mult;
  logic signed [pid_pkg::DW+1:0]   err_dif;  // 16 bit difference
  logic signed [2*pid_pkg::DW+1:0] kd_mult;  // 14 x 16 -> 30 bit
  logic signed [pid_pkg::IW:0]     int_sum;  // one guard bit

  logic signed [2*pid_pkg::DW-pid_pkg::PSR:0]   p_reg;    // 17 bit
  logic signed [pid_pkg::IW-1:0]                int_reg;  // accumulator
  logic signed [2*pid_pkg::DW+1-pid_pkg::DSR:0] d_reg;    // 20 bit

  assign kp_mult = kp_i * err;
  assign ki_mult = ki_i * err;
  assign err_dif = err - err_prev;
  assign kd_mult = kd_i * err_dif;
  assign int_sum = int_reg + ki_mult;  // ki_mult sign extended

  always_ff @(posedge clk) begin
    if (!rstn) begin
      p_reg <= '0;
      d_reg <= '0;
    end else begin
      // dropping low bits of a signed word is an arithmetic shift
      p_reg <= kp_mult[2*pid_pkg::DW:pid_pkg::PSR];
      d_reg <= kd_mult[2*pid_pkg::DW+1:pid_pkg::DSR];
    end
  end

  // integrator, clamps at the accumulator limits instead of wrapping
  always_ff @(posedge clk) begin
    if (!rstn) begin
      int_reg <= '0;
    end else if (irst_i) begin
      int_reg <= '0;  // held clear by the global reset bit
    end else if (int_sum[pid_pkg::IW:pid_pkg::IW-1] == 2'b01) begin
      int_reg <= {1'b0, {(pid_pkg::IW-1){1'b1}}};  // positive limit
    end else if (int_sum[pid_pkg::IW:pid_pkg::IW-1] == 2'b10) begin
      int_reg <= {1'b1, {(pid_pkg::IW-1){1'b0}}};  // negative limit
    end else begin
      int_reg <= int_sum[pid_pkg::IW-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 3, sum and clamp
  ////////////////////////////////////////////////////////////

  logic signed [pid_pkg::IW-pid_pkg::ISR-1:0]     i_term;   // 14 bit
  logic signed [2*pid_pkg::DW+2-pid_pkg::DSR:0]   pid_sum;  // 21 bit

  assign i_term  = int_reg[pid_pkg::IW-1:pid_pkg::ISR];  // int >>> ISR
  // widest term is D at 20 bit, 21 bit holds all three
  assign pid_sum = p_reg + i_term + d_reg;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pid_o <= '0;
    end else if (pid_sum > pid_pkg::SAT_MAX) begin
      pid_o <= pid_pkg::SAT_MAX;
    end else if (pid_sum < pid_pkg::SAT_MIN) begin
      pid_o <= pid_pkg::SAT_MIN;
    end else begin
      pid_o <= pid_sum[pid_pkg::DW-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a cleared integrator holds no history into the next cycle
  a_irst_clears: assert property (
    @(posedge clk) disable iff (!rstn)
    irst_i |=> (int_reg == '0)
  );

endmodule

//--- hw/pid_pkg.sv
////////////////////////////////////////////////////////////
// pid package
// data widths, scaling shifts and register map shared
// by the 2x2 MIMO PID controller
////////////////////////////////////////////////////////////

package pid_pkg;

  ////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////

  localparam int DW   = 14;         // sample and setting width
  localparam int CNI  = 2;          // input channels
  localparam int CNO  = 2;          // output channels
  localparam int NBLK = CNO * CNI;  // pid blocks, index o*2+i

  // output clamp limits for 14 bit signed
  localparam logic signed [DW-1:0] SAT_MAX = {1'b0, {(DW-1){1'b1}}};  // 8191
  localparam logic signed [DW-1:0] SAT_MIN = {1'b1, {(DW-1){1'b0}}};  // -8192

  // gain scaling, arithmetic right shifts
  localparam int PSR = 12;  // proportional
  localparam int ISR = 18;  // integral
  localparam int DSR = 10;  // derivative
  localparam int IW  = 32;  // integrator accumulator width

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  // bit 6 low  -> global integrator reset register
  // bit 6 high -> block settings, bits 5:4 = {o,i}
  localparam int ADR_SEL_BIT = 6;
  localparam int ADR_BLK_LSB = 4;  // lowest block index bit

  // offsets inside one block
  localparam int OFS_SP = 0;   // set point
  localparam int OFS_KP = 4;   // proportional gain
  localparam int OFS_KI = 8;   // integral gain
  localparam int OFS_KD = 12;  // derivative gain

endpackage

//--- hw/pid_regs.sv
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// pid register file
// wishbone classic slave with the per block settings and
// the global integrator reset bits, with readback
////////////////////////////////////////////////////////////

module pid_regs (
  input  logic                                        clk,
  input  logic                                        rstn,
  // wishbone classic slave
  input  logic                                        wb_cyc_i,
  input  logic                                        wb_stb_i,
  input  logic                                        wb_we_i,
  input  logic [31:0]                                 wb_adr_i,
  input  logic [31:0]                                 wb_dat_i,
  input  logic [3:0]                                  wb_sel_i,  // full words only
  output logic [31:0]                                 wb_dat_o,
  output logic                                        wb_ack_o,
  // settings, index o*2+i
  output logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] sp_o,
  output logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] kp_o,
  output logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] ki_o,
  output logic signed [pid_pkg::NBLK-1:0][pid_pkg::DW-1:0] kd_o,
  output logic        [pid_pkg::NBLK-1:0]                  irst_o
);

  ////////////////////////////////////////////////////////////
  // bus handshake and decode
  ////////////////////////////////////////////////////////////

  logic                               req;      // new transfer seen
  logic                               wr_en;
  logic                               blk_sel;  // 1 = block settings
  logic [$clog2(pid_pkg::NBLK)-1:0]   blk;      // {o,i}
  logic [pid_pkg::ADR_BLK_LSB-1:0]    ofs;      // offset in block

  // wb_sel_i is not decoded, every register is written whole
  assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en   = req & wb_we_i;  // lands on the ack edge
  assign blk_sel = wb_adr_i[pid_pkg::ADR_SEL_BIT];
  assign blk     = wb_adr_i[pid_pkg::ADR_SEL_BIT-1:pid_pkg::ADR_BLK_LSB];
  assign ofs     = wb_adr_i[pid_pkg::ADR_BLK_LSB-1:0];

  // single cycle ack, one cycle after the request
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sp_o   <= '0;
      kp_o   <= '0;
      ki_o   <= '0;
      kd_o   <= '0;
      irst_o <= '1;  // integrators start held in reset
    end else if (wr_en) begin
      if (!blk_sel) begin
        irst_o <= wb_dat_i[pid_pkg::NBLK-1:0];  // global register
      end else begin
        case (ofs)
          pid_pkg::OFS_SP: sp_o[blk] <= wb_dat_i[pid_pkg::DW-1:0];
          pid_pkg::OFS_KP: kp_o[blk] <= wb_dat_i[pid_pkg::DW-1:0];
          pid_pkg::OFS_KI: ki_o[blk] <= wb_dat_i[pid_pkg::DW-1:0];
          pid_pkg::OFS_KD: kd_o[blk] <= wb_dat_i[pid_pkg::DW-1:0];
          default: ;  // unused offset, write dropped
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  // loaded with the request, so valid while ack is high
  always_ff @(posedge clk) begin
    if (req) begin
      if (!blk_sel) begin
        wb_dat_o <= {{(32-pid_pkg::NBLK){1'b0}}, irst_o};
      end else begin
        case (ofs)
          pid_pkg::OFS_SP: wb_dat_o <= {{(32-pid_pkg::DW){1'b0}}, sp_o[blk]};
          pid_pkg::OFS_KP: wb_dat_o <= {{(32-pid_pkg::DW){1'b0}}, kp_o[blk]};
          pid_pkg::OFS_KI: wb_dat_o <= {{(32-pid_pkg::DW){1'b0}}, ki_o[blk]};
          pid_pkg::OFS_KD: wb_dat_o <= {{(32-pid_pkg::DW){1'b0}}, kd_o[blk]};
          default:         wb_dat_o <= '0;  // hole in the map
        endcase
      end
    end
  end

  // ack never stretches, the master gets no back-pressure
  a_ack_single: assert property (
    @(posedge clk) disable iff (!rstn)
    wb_ack_o |=> !wb_ack_o
  );

endmodule

//--- tb.f
hw/pid_pkg.sv
hw/pid_block.sv
hw/mimo_sum_sat.sv
hw/pid_regs.sv
hw/mimo_pid_top.sv
tests/tb_clkgen.sv
tests/mimo_pid_tb.sv

//--- tests/mimo_pid_tb.sv
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// mimo pid testbench
// wishbone setup, random and shaped sample streams, and a
// cycle stepped reference model compared on every cycle
////////////////////////////////////////////////////////////

module mimo_pid_tb;

  // run length in cycles where each bus transfer takes 4
  localparam int P_LEN   = 200;
  localparam int I_LEN   = 300;
  localparam int HOLD    = 20;   // cycles per flat input level
  localparam int N_STEP  = 8;
  localparam int N_XFER  = 118;  // 18 + 32 + 17 + 19 + 16 + 16
  localparam int RUN_CYC = 24 + P_LEN + I_LEN + (N_STEP + 4) * (HOLD + 1) + 8;
  localparam int MAX_CYC = 2 * (RUN_CYC + 4 * N_XFER);
  localparam longint OUT_MAX = (longint'(1) << (pid_pkg::DW - 1)) - 1;
  localparam longint OUT_MIN = -(longint'(1) << (pid_pkg::DW - 1));
  localparam longint INT_MAX = (longint'(1) << (pid_pkg::IW - 1)) - 1;
  localparam longint INT_MIN = -(longint'(1) << (pid_pkg::IW - 1));

  logic clk;
  logic rstn;
  logic signed [pid_pkg::CNI-1:0][pid_pkg::DW-1:0] din;
  logic signed [pid_pkg::CNO-1:0][pid_pkg::DW-1:0] dat_o;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_wdat;
  logic [3:0]  wb_sel;
  logic [31:0] wb_rdat;
  logic        wb_ack;

  // shadow of the register file moved on each write's ack edge
  logic signed [pid_pkg::DW-1:0] sh_sp [pid_pkg::NBLK];
  logic signed [pid_pkg::DW-1:0] sh_kp [pid_pkg::NBLK];
  logic signed [pid_pkg::DW-1:0] sh_ki [pid_pkg::NBLK];
  logic signed [pid_pkg::DW-1:0] sh_kd [pid_pkg::NBLK];
  logic        [pid_pkg::NBLK-1:0] sh_irst;
  // model pipeline state per block then per output
  longint m_err [pid_pkg::NBLK];
  longint m_errp [pid_pkg::NBLK];
  longint m_p [pid_pkg::NBLK];
  longint m_int [pid_pkg::NBLK];
  longint m_d [pid_pkg::NBLK];
  longint m_pid [pid_pkg::NBLK];
  longint m_out [pid_pkg::CNO];

  logic [31:0] lfsr = 32'h1167_7ed6;
  int          err_cnt;
  int          chk_cnt;
  int          cyc_cnt;

  tb_clkgen clkgen0 (.clk_o(clk), .rstn_o(rstn));

  mimo_pid_top dut0 (
    .clk (clk), .rstn (rstn), .dat_i (din), .dat_o (dat_o),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat), .wb_sel_i (wb_sel), .wb_dat_o (wb_rdat), .wb_ack_o (wb_ack)
  );

  ////////////////////////////////////////////////////////////
  // galois lfsr random numbers stepped once per bit
  ////////////////////////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'hD000_0001;  // taps 32 31 29 1
    return b;
  endfunction

  // n random bits sign extended to a 14 bit word
  function automatic logic signed [pid_pkg::DW-1:0] rand_s(input int n);
    logic [31:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) v[k] = lfsr_bit();
    if (v[n-1]) v = v | (32'hFFFF_FFFF << n);
    return v[pid_pkg::DW-1:0];
  endfunction

  task automatic check_val(input string what, input logic signed [63:0] got,
                           input logic signed [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic longint clamp(input longint v, input longint lo, input longint hi);
    return (v > hi) ? hi : (v < lo) ? lo : v;
  endfunction

  // one clock of all four blocks and both summers with later stages first
  function automatic void model_step();
    int     k;
    longint s;
    for (k = 0; k < pid_pkg::CNO; k++)
      m_out[k] = clamp(m_pid[k*pid_pkg::CNI] + m_pid[k*pid_pkg::CNI+1], OUT_MIN, OUT_MAX);
    for (k = 0; k < pid_pkg::NBLK; k++) begin
      m_pid[k]  = clamp(m_p[k] + (m_int[k] >>> pid_pkg::ISR) + m_d[k], OUT_MIN, OUT_MAX);
      m_p[k]    = (longint'(sh_kp[k]) * m_err[k]) >>> pid_pkg::PSR;
      m_d[k]    = (longint'(sh_kd[k]) * (m_err[k] - m_errp[k])) >>> pid_pkg::DSR;
      s         = m_int[k] + longint'(sh_ki[k]) * m_err[k];
      m_int[k]  = sh_irst[k] ? 0 : clamp(s, INT_MIN, INT_MAX);
      m_errp[k] = m_err[k];
      m_err[k]  = longint'(sh_sp[k]) - longint'($signed(din[k % pid_pkg::CNI]));
    end
  endfunction

  function automatic void model_reset();
    int k;
    for (k = 0; k < pid_pkg::NBLK; k++) begin
      {m_err[k], m_errp[k], m_p[k], m_int[k], m_d[k], m_pid[k]} = '0;
      {sh_sp[k], sh_kp[k], sh_ki[k], sh_kd[k]} = '0;
    end
    m_out[0] = 0;
    m_out[1] = 0;
    sh_irst  = '1;  // integrators start cleared
  endfunction

  function automatic void shadow_write(input logic [31:0] adr, input logic [31:0] dat);
    int b;
    b = (adr >> pid_pkg::ADR_BLK_LSB) & (pid_pkg::NBLK - 1);
    if (!adr[pid_pkg::ADR_SEL_BIT]) sh_irst = dat[pid_pkg::NBLK-1:0];
    else case (adr[pid_pkg::ADR_BLK_LSB-1:0])
      pid_pkg::OFS_SP: sh_sp[b] = dat[pid_pkg::DW-1:0];
      pid_pkg::OFS_KP: sh_kp[b] = dat[pid_pkg::DW-1:0];
      pid_pkg::OFS_KI: sh_ki[b] = dat[pid_pkg::DW-1:0];
      pid_pkg::OFS_KD: sh_kd[b] = dat[pid_pkg::DW-1:0];
      default: ;
    endcase
  endfunction

  // pre edge values everywhere as the DUT registers see them
  always @(posedge clk) begin
    cyc_cnt++;
    if (!rstn) model_reset();
    else begin
      model_step();
      if (wb_cyc && wb_stb && wb_we && !wb_ack) shadow_write(wb_adr, wb_wdat);
    end
  end

  // outputs settled half a cycle after the edge
  always @(negedge clk) begin : compare
    int o;
    if (rstn)
      for (o = 0; o < pid_pkg::CNO; o++)
        check_val($sformatf("dat_o[%0d]", o), $signed(dat_o[o]), m_out[o]);
  end

  initial begin : watchdog
    wait (cyc_cnt >= MAX_CYC);
    $display("timeout: run still busy after %0d cycles", MAX_CYC);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // wishbone and stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic wb_xfer(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat);
    @(posedge clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_wdat <= wdat;
    @(posedge clk);
    while (!wb_ack) @(posedge clk);  // held until the slave answers
    rdat = wb_rdat;  // valid with ack
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(posedge clk);
    check_val("ack longer than one cycle", wb_ack, 0);
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_xfer(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    wb_xfer(1'b0, adr, '0, dat);
  endtask

  function automatic logic [31:0] blk_adr(input int b, input int ofs);
    return (32'd1 << pid_pkg::ADR_SEL_BIT) | (b << pid_pkg::ADR_BLK_LSB) | ofs;
  endfunction

  task automatic set_block(input int b, input logic [pid_pkg::DW-1:0] sp, kp, ki, kd);
    wb_write(blk_adr(b, pid_pkg::OFS_SP), sp);
    wb_write(blk_adr(b, pid_pkg::OFS_KP), kp);
    wb_write(blk_adr(b, pid_pkg::OFS_KI), ki);
    wb_write(blk_adr(b, pid_pkg::OFS_KD), kd);
  endtask

  task automatic drive_random(input int n);
    repeat (n) begin
      @(posedge clk);
      din[0] <= rand_s(pid_pkg::DW);
      din[1] <= rand_s(pid_pkg::DW);
    end
  endtask

  task automatic hold_input(input logic signed [pid_pkg::DW-1:0] a, b);
    @(posedge clk);
    din[0] <= a;
    din[1] <= b;
    repeat (HOLD) @(posedge clk);  // long past the 4 cycle latency
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0]             rd;
    logic [pid_pkg::DW-1:0]  val [pid_pkg::NBLK][4];
    int                      b;
    int                      r;
    din     = '0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    wb_sel  = 4'hF;  // whole words only
    wait (rstn);
    repeat (4) @(posedge clk);

    // reset values
    check_val("dat_o[0] after reset", $signed(dat_o[0]), 0);
    check_val("dat_o[1] after reset", $signed(dat_o[1]), 0);
    wb_read(32'h0, rd);
    check_val("global irst after reset", rd, 32'hF);
    for (b = 0; b < pid_pkg::NBLK; b++)
      for (r = 0; r < 4; r++) begin
        wb_read(blk_adr(b, 4 * r), rd);
        check_val($sformatf("block %0d reg %0d after reset", b, r), rd, 0);
      end

    // readback is zero extended
    for (b = 0; b < pid_pkg::NBLK; b++)
      for (r = 0; r < 4; r++) begin
        val[b][r] = rand_s(pid_pkg::DW);
        wb_write(blk_adr(b, 4 * r), val[b][r]);
      end
    for (b = 0; b < pid_pkg::NBLK; b++)
      for (r = 0; r < 4; r++) begin
        wb_read(blk_adr(b, 4 * r), rd);
        check_val($sformatf("readback block %0d reg %0d", b, r), rd,
                  {{(32 - pid_pkg::DW){1'b0}}, val[b][r]});
      end
    // hole next to a set point that now holds a nonzero value
    wb_read(blk_adr(0, 2), rd);
    check_val("unused offset", rd, 0);

    // proportional only with integrators held
    for (b = 0; b < pid_pkg::NBLK; b++) set_block(b, 0, rand_s(pid_pkg::DW), 0, 0);
    wb_write(32'h0, 32'hF);
    drive_random(P_LEN);

    // integral then clear again
    for (b = 0; b < pid_pkg::NBLK; b++) set_block(b, rand_s(pid_pkg::DW), 0, rand_s(9), 0);
    wb_write(32'h0, 32'h0);
    drive_random(I_LEN);
    wb_write(32'h0, 32'h5);  // blocks (0,0) and (1,0)
    drive_random(HOLD);
    wb_write(32'h0, 32'hF);
    drive_random(HOLD);
    check_val("dat_o[0] integrators cleared", $signed(dat_o[0]), 0);
    check_val("dat_o[1] integrators cleared", $signed(dat_o[1]), 0);

    // derivative on steps where flat input gives no output
    for (b = 0; b < pid_pkg::NBLK; b++) set_block(b, 0, 0, 0, rand_s(pid_pkg::DW));
    repeat (N_STEP) begin
      hold_input(rand_s(pid_pkg::DW), rand_s(pid_pkg::DW));
      check_val("dat_o[0] flat after step", $signed(dat_o[0]), 0);
      check_val("dat_o[1] flat after step", $signed(dat_o[1]), 0);
    end

    // saturation with opposite gains on output 1
    for (b = 0; b < pid_pkg::NBLK; b++)
      set_block(b, 0, (b < pid_pkg::CNI) ? pid_pkg::SAT_MAX : pid_pkg::SAT_MIN, 0, 0);
    hold_input(pid_pkg::SAT_MIN, pid_pkg::SAT_MIN);
    check_val("dat_o[0] clamp high", $signed(dat_o[0]), 8191);
    check_val("dat_o[1] clamp low", $signed(dat_o[1]), -8192);
    hold_input(pid_pkg::SAT_MAX, pid_pkg::SAT_MAX);
    check_val("dat_o[0] clamp low", $signed(dat_o[0]), -8192);
    check_val("dat_o[1] clamp high", $signed(dat_o[1]), 8191);
    repeat (8) @(posedge clk);

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) $display("*** TEST PASSED ***");
    else $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// testbench clock and reset
// 8 ns clock, reset held low for the first 16 cycles
////////////////////////////////////////////////////////////

module tb_clkgen (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 125 MHz
  end

  initial begin
    rstn_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rstn_o <= 1'b1;  // released on an edge like any other input
  end

endmodule
